//--- src/eeprom_pkg.sv
package eeprom_pkg;

    localparam logic [3:0] DEV_CODE = 4'b1010; // serial eeprom type id

    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] block; // address bits 10:8
        logic       rnw;
    } eeprom_ctrl_fields_t;

    // same byte seen as fields when built, as raw bits when shifted
    typedef union packed {
        logic [7:0]          raw;
        eeprom_ctrl_fields_t f;
    } eeprom_ctrl_byte_u;

    typedef enum logic [1:0] {
        TX_START,
        TX_RSTART,
        TX_BYTE,
        TX_STOP
    } tx_op_e;

    typedef struct packed {
        tx_op_e     op;
        logic [7:0] data; // only used for TX_BYTE
    } tx_cmd_t;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       err; // slave gave no ack
    } eeprom_resp_t;

endpackage

//--- src/i2c_tx_shifter.sv
`timescale 1ns/1ps

module i2c_tx_shifter
    import eeprom_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET,
    input  logic    scl_low_mid,
    input  logic    scl_high_mid,
    input  logic    tx_go,
    input  tx_cmd_t tx_cmd,
    input  logic    sda_in,
    output logic    sda_pull,
    output logic    tx_done,
    output logic    tx_nack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOW,
        ST_HIGH
    } state_e;

    state_e     state;
    tx_op_e     op;
    logic [7:0] shreg;
    logic [3:0] bit_cnt;
    logic       ack_slot;

    assign ack_slot = (bit_cnt == 4'd8); // ninth bit of a byte

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            sda_pull <= 1'b0;
            tx_done  <= 1'b0;
            tx_nack  <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            tx_nack <= 1'b0;
            case (state)
                ST_IDLE:
                    if (tx_go)
                    begin
                        bit_cnt <= '0;
                        state   <= ST_LOW;
                    end
                ST_LOW:
                    if (scl_low_mid)
                    begin
                        case (op)
                            TX_STOP: sda_pull <= 1'b1; // low before the rising edge
                            TX_BYTE: sda_pull <= ~ack_slot & ~shreg[7];
                            default: sda_pull <= 1'b0; // start needs sda high first
                        endcase
                        state <= ST_HIGH;
                    end
                ST_HIGH:
                    if (scl_high_mid)
                    begin
                        if (op == TX_BYTE && !ack_slot)
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            state   <= ST_LOW;
                        end
                        else
                        begin
                            tx_done <= 1'b1;
                            tx_nack <= (op == TX_BYTE) & sda_in; // released line means nack
                            state   <= ST_IDLE;
                            if (op != TX_BYTE)
                                sda_pull <= (op != TX_STOP); // sda edge while scl high
                        end
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && tx_go)
        begin
            op    <= tx_cmd.op;
            shreg <= tx_cmd.data;
        end
        else if (state == ST_LOW && scl_low_mid && op == TX_BYTE)
        begin
            shreg <= {shreg[6:0], 1'b0}; // msb first
        end
    end

endmodule

//--- src/i2c_rx_shifter.sv
`timescale 1ns/1ps

module i2c_rx_shifter (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       scl_low_mid,
    input  logic       scl_high_mid,
    input  logic       rx_go,
    input  logic       sda_in,
    output logic       sda_pull,
    output logic       rx_done,
    output logic [7:0] rx_byte
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOW,
        ST_HIGH
    } state_e;

    state_e     state;
    logic [3:0] bit_cnt;
    logic       ack_slot;

    assign ack_slot = (bit_cnt == 4'd8);

    // single read only, so the ninth bit stays released as nack
    assign sda_pull = 1'b0;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            case (state)
                ST_IDLE:
                    if (rx_go)
                    begin
                        bit_cnt <= '0;
                        state   <= ST_LOW;
                    end
                ST_LOW:
                    if (scl_low_mid)
                        state <= ST_HIGH; // slave sets up its bit here
                ST_HIGH:
                    if (scl_high_mid)
                    begin
                        if (ack_slot)
                        begin
                            rx_done <= 1'b1;
                            state   <= ST_IDLE;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            state   <= ST_LOW;
                        end
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_HIGH && scl_high_mid && !ack_slot)
            rx_byte <= {rx_byte[6:0], sda_in}; // msb arrives first
    end

endmodule

//--- src/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer
    import eeprom_pkg::*;
#(
    parameter int SCL_HALF = 2
)
(
    input  logic         CLK,
    input  logic         RESET,
    input  eeprom_req_t  req,
    input  logic         tx_done,
    input  logic         tx_nack,
    input  logic         rx_done,
    input  logic [7:0]   rx_byte,
    input  logic         tx_pull,
    input  logic         rx_pull,
    output logic         scl,
    output logic         sda_oe,
    output logic         scl_low_mid,
    output logic         scl_high_mid,
    output logic         tx_go,
    output tx_cmd_t      tx_cmd,
    output logic         rx_go,
    output logic         busy,
    output logic         done,
    output eeprom_resp_t resp
);

    localparam int CW = $clog2(SCL_HALF);
    localparam logic [CW-1:0] LAST = CW'(SCL_HALF - 1);
    localparam logic [CW-1:0] MID  = CW'((SCL_HALF - 1) / 2); // early in phase

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_WDATA,
        S_RSTART,
        S_CTRL_RD,
        S_RDATA,
        S_STOP
    } state_e;

    state_e            state;
    state_e            nxt;
    logic              run;
    logic [CW-1:0]     cnt;
    logic              accept;
    logic              finish;
    logic              rd_q;
    logic [10:0]       addr_q;
    logic [7:0]        wdata_q;
    logic [7:0]        rdata_q;
    logic              err_q;
    eeprom_ctrl_byte_u ctrl;

    assign accept       = (state == S_IDLE) && (req.wr || req.rd);
    assign finish       = (state == S_STOP) && tx_done;
    assign busy         = (state != S_IDLE);
    assign sda_oe       = tx_pull | rx_pull;
    assign scl_low_mid  = run && !scl && (cnt == MID);
    assign scl_high_mid = run && scl && (cnt == MID);

    // scl runs only between acceptance and the end of stop
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            run <= 1'b0;
            scl <= 1'b1;
            cnt <= '0;
        end
        else if (accept)
        begin
            run <= 1'b1;
            scl <= 1'b0;
            cnt <= '0;
        end
        else if (finish)
        begin
            run <= 1'b0; // parked high after stop
            cnt <= '0;
        end
        else if (run)
        begin
            if (cnt == LAST)
            begin
                cnt <= '0;
                scl <= ~scl;
            end
            else
                cnt <= cnt + CW'(1);
        end
    end

    always_comb
    begin
        nxt = state;
        case (state)
            S_IDLE:    if (accept) nxt = S_START;
            S_START:   if (tx_done) nxt = S_CTRL_WR;
            S_CTRL_WR: if (tx_done) nxt = tx_nack ? S_STOP : S_ADDR;
            S_ADDR:    if (tx_done) nxt = tx_nack ? S_STOP : (rd_q ? S_RSTART : S_WDATA);
            S_WDATA:   if (tx_done) nxt = S_STOP;
            S_RSTART:  if (tx_done) nxt = S_CTRL_RD;
            S_CTRL_RD: if (tx_done) nxt = tx_nack ? S_STOP : S_RDATA;
            S_RDATA:   if (rx_done) nxt = S_STOP;
            S_STOP:    if (tx_done) nxt = S_IDLE;
            default:   nxt = S_IDLE;
        endcase
    end

    // go issued on the step edge so the next low_mid is not missed
    assign tx_go = (nxt != state) && (nxt != S_IDLE) && (nxt != S_RDATA);
    assign rx_go = (nxt != state) && (nxt == S_RDATA);

    always_comb
    begin
        ctrl.f.dev   = DEV_CODE;
        ctrl.f.block = addr_q[10:8];
        ctrl.f.rnw   = (nxt == S_CTRL_RD);
        tx_cmd.op    = TX_BYTE;
        tx_cmd.data  = ctrl.raw;
        case (nxt)
            S_START:  tx_cmd.op = TX_START;
            S_RSTART: tx_cmd.op = TX_RSTART;
            S_STOP:   tx_cmd.op = TX_STOP;
            S_ADDR:   tx_cmd.data = addr_q[7:0];
            S_WDATA:  tx_cmd.data = wdata_q;
            default:  tx_cmd.data = ctrl.raw;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= S_IDLE;
            err_q <= 1'b0;
            done  <= 1'b0;
            resp  <= '0;
        end
        else
        begin
            state <= nxt;
            done  <= finish;
            if (accept)
                err_q <= 1'b0;
            else if (tx_done && tx_nack)
                err_q <= 1'b1;
            if (finish)
            begin
                resp.rdata <= rdata_q;
                resp.err   <= err_q;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            rd_q    <= !req.wr; // write wins
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            rdata_q <= '0;
        end
        else if (rx_done)
            rdata_q <= rx_byte;
    end

endmodule

//--- src/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top
    import eeprom_pkg::*;
#(
    parameter int SCL_HALF = 2 // clk cycles per scl phase
)
(
    input  logic         CLK,
    input  logic         RESET,
    input  eeprom_req_t  req,
    input  logic         sda_in,
    output logic         busy,
    output logic         done,
    output eeprom_resp_t resp,
    output logic         scl,
    output logic         sda_oe
);

    logic       scl_low_mid;
    logic       scl_high_mid;
    logic       tx_go;
    tx_cmd_t    tx_cmd;
    logic       tx_done;
    logic       tx_nack;
    logic       tx_pull;
    logic       rx_go;
    logic       rx_done;
    logic [7:0] rx_byte;
    logic       rx_pull;

    i2c_tx_shifter i_tx_shifter (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl_low_mid  (scl_low_mid),
        .scl_high_mid (scl_high_mid),
        .tx_go        (tx_go),
        .tx_cmd       (tx_cmd),
        .sda_in       (sda_in),
        .sda_pull     (tx_pull),
        .tx_done      (tx_done),
        .tx_nack      (tx_nack)
    );

    i2c_rx_shifter i_rx_shifter (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl_low_mid  (scl_low_mid),
        .scl_high_mid (scl_high_mid),
        .rx_go        (rx_go),
        .sda_in       (sda_in),
        .sda_pull     (rx_pull),
        .rx_done      (rx_done),
        .rx_byte      (rx_byte)
    );

    eeprom_sequencer #(
        .SCL_HALF (SCL_HALF)
    ) i_sequencer (
        .CLK          (CLK),
        .RESET        (RESET),
        .req          (req),
        .tx_done      (tx_done),
        .tx_nack      (tx_nack),
        .rx_done      (rx_done),
        .rx_byte      (rx_byte),
        .tx_pull      (tx_pull),
        .rx_pull      (rx_pull),
        .scl          (scl),
        .sda_oe       (sda_oe),
        .scl_low_mid  (scl_low_mid),
        .scl_high_mid (scl_high_mid),
        .tx_go        (tx_go),
        .tx_cmd       (tx_cmd),
        .rx_go        (rx_go),
        .busy         (busy),
        .done         (done),
        .resp         (resp)
    );

endmodule

//--- verification/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic refuse,
    output logic sda_pull
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_READ
    } mstate_e;

    logic [7:0] mem [0:2047];
    mstate_e    state;
    logic [7:0] shreg;
    logic [7:0] rdata;
    logic [3:0] bit_cnt;
    logic       ack_phase;
    logic       rnw;
    logic       ok;
    logic [2:0] block;
    logic [7:0] word;
    logic       scl_q;
    logic       sda_q;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'((i * 13) ^ (i >> 8)); // pattern over the full address
        state     = M_IDLE;
        sda_pull  = 1'b0;
        ack_phase = 1'b0;
        bit_cnt   = '0;
        rnw       = 1'b0;
        block     = '0;
        word      = '0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
    end

    always @(scl or sda)
    begin
        if (scl_q && scl && sda_q && !sda)
        begin
            state     = M_CTRL; // start or repeated start
            bit_cnt   = '0;
            ack_phase = 1'b0;
            sda_pull  = 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            state     = M_IDLE; // stop
            ack_phase = 1'b0;
            sda_pull  = 1'b0;
        end
        else if (!scl_q && scl)
        begin
            if (state == M_READ)
                bit_cnt = bit_cnt + 4'd1;
            else if (state != M_IDLE && !ack_phase && bit_cnt < 4'd8)
            begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 4'd1;
            end
        end
        else if (scl_q && !scl)
        begin
            if (ack_phase)
            begin
                ack_phase = 1'b0;
                sda_pull  = 1'b0;
                bit_cnt   = '0;
                case (state)
                    M_CTRL:
                        if (rnw)
                        begin
                            state    = M_READ;
                            rdata    = mem[{block, word}];
                            sda_pull = ~rdata[7];
                        end
                        else
                            state = M_ADDR;
                    M_ADDR:  state = M_WDATA;
                    default: state = M_IDLE; // no page writes
                endcase
            end
            else if (state == M_READ)
                sda_pull = (bit_cnt < 4'd8) ? ~rdata[3'd7 - bit_cnt[2:0]] : 1'b0;
            else if (state != M_IDLE && bit_cnt == 4'd8)
            begin
                ok = !refuse;
                case (state)
                    M_CTRL:
                    begin
                        ok    = ok && (shreg[7:4] == 4'b1010);
                        block = shreg[3:1];
                        rnw   = shreg[0];
                    end
                    M_ADDR:  word = shreg;
                    default: if (ok) mem[{block, word}] = shreg;
                endcase
                if (ok)
                begin
                    sda_pull  = 1'b1;
                    ack_phase = 1'b1;
                end
                else
                    state = M_IDLE; // stay off the bus until next start
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- verification/eeprom_ctrl_assertions.sv
`timescale 1ns/1ps

module eeprom_ctrl_assertions (
    input logic CLK,
    input logic RESET,
    input logic busy,
    input logic done,
    input logic scl,
    input logic sda_oe
);

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done longer than one cycle");

    // busy drops in the same cycle that done rises
    a_busy_hold: assert property (@(posedge CLK) disable iff (RESET) busy |=> (busy || done))
        else $error("busy fell without done");

    a_scl_idle: assert property (@(posedge CLK) disable iff (RESET) !busy |-> scl)
        else $error("scl low while idle");

    a_sda_idle: assert property (@(posedge CLK) disable iff (RESET) !busy |-> !sda_oe)
        else $error("sda pulled while idle");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_assertions i_assertions (.*);

//--- verification/tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl
    import eeprom_pkg::*;
;

    localparam int SCL_HALF = 2;
    // about 60 transfers of at most 41 scl periods, plus the idle watch
    localparam int TIMEOUT_CYCLES = 60 * 41 * 2 * SCL_HALF + 1000;

    logic         CLK = 1'b0;
    logic         RESET;
    eeprom_req_t  req;
    logic         busy;
    logic         done;
    eeprom_resp_t resp;
    logic         scl;
    logic         sda_oe;
    logic         sda;
    logic         model_pull;
    logic         refuse;
    int           cycles = 0;
    int           err_count = 0;

    assign sda = ~sda_oe & ~model_pull; // open-drain wired and

    eeprom_ctrl_top #(
        .SCL_HALF (SCL_HALF)
    ) i_eeprom_ctrl_top (
        .CLK    (CLK),
        .RESET  (RESET),
        .req    (req),
        .sda_in (sda),
        .busy   (busy),
        .done   (done),
        .resp   (resp),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

    eeprom_model i_model (
        .scl      (scl),
        .sda      (sda),
        .refuse   (refuse),
        .sda_pull (model_pull)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("=== FAIL ===");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            err_count++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_resp(input eeprom_resp_t got, input eeprom_resp_t exp,
                              input string what);
        if (got !== exp)
        begin
            err_count++;
            $display("ERR %0t: %s resp data %h err %b, expected data %h err %b",
                     $time, what, got.rdata, got.err, exp.rdata, exp.err);
            $display("=== FAIL ===");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic send_req(input logic wr, input logic [10:0] addr, input logic [7:0] data);
        eeprom_req_t r;
        r.wr    = wr;
        r.rd    = !wr;
        r.addr  = addr;
        r.wdata = data;
        @(posedge CLK);
        req <= r;
        @(posedge CLK);
        req <= '0;
    endtask

    task automatic wait_done;
        do
            @(negedge CLK);
        while (!done);
    endtask

    task automatic run_write(input logic [10:0] addr, input logic [7:0] data,
                             input logic exp_err);
        send_req(1'b1, addr, data);
        wait_done();
        check_bit(resp.err, exp_err, "write error flag");
    endtask

    task automatic run_read(input logic [10:0] addr, input logic [7:0] exp_data,
                            input logic exp_err);
        eeprom_resp_t exp;
        exp.rdata = exp_data;
        exp.err   = 1'b0;
        send_req(1'b0, addr, 8'h00);
        wait_done();
        if (exp_err)
            check_bit(resp.err, 1'b1, "read error flag");
        else
            check_resp(resp, exp, "read");
    endtask

    task automatic test_reset_state;
        repeat (5)
        begin
            @(negedge CLK);
            check_bit(busy, 1'b0, "busy after reset");
            check_bit(done, 1'b0, "done after reset");
            check_bit(sda_oe, 1'b0, "sda_oe after reset");
            check_bit(scl, 1'b1, "scl after reset");
            check_resp(resp, '0, "after reset");
        end
    endtask

    task automatic test_write_read;
        run_write(11'h123, 8'h5a, 1'b0);
        run_read(11'h123, 8'h5a, 1'b0);
    endtask

    task automatic test_blocks;
        // same low byte, only the block bits differ
        run_write(11'h044, 8'h11, 1'b0);
        run_write(11'h344, 8'h33, 1'b0);
        run_write(11'h744, 8'h77, 1'b0);
        run_read(11'h044, 8'h11, 1'b0);
        run_read(11'h344, 8'h33, 1'b0);
        run_read(11'h744, 8'h77, 1'b0);
    endtask

    task automatic test_refusal;
        run_write(11'h2a0, 8'hc5, 1'b0);
        @(posedge CLK);
        refuse <= 1'b1;
        run_write(11'h2a0, 8'h0f, 1'b1);
        run_read(11'h2a0, 8'h00, 1'b1);
        @(posedge CLK);
        refuse <= 1'b0;
        run_read(11'h2a0, 8'hc5, 1'b0);
    endtask

    task automatic test_busy_strobe;
        eeprom_req_t r;
        r.wr    = 1'b1;
        r.rd    = 1'b0;
        r.addr  = 11'h5b1;
        r.wdata = 8'hc3;
        run_write(11'h5b1, 8'h3c, 1'b0);
        send_req(1'b1, 11'h0e2, 8'h96);
        do
            @(negedge CLK);
        while (!busy);
        @(posedge CLK);
        req <= r; // dropped while the controller is busy
        @(posedge CLK);
        req <= '0;
        wait_done();
        check_bit(resp.err, 1'b0, "write error flag");
        repeat (300)
        begin
            @(negedge CLK);
            check_bit(done, 1'b0, "done after dropped strobe");
        end
        run_read(11'h5b1, 8'h3c, 1'b0);
        run_read(11'h0e2, 8'h96, 1'b0);
    endtask

    task automatic test_random;
        logic [7:0]  mirror [logic [10:0]];
        logic [10:0] addrs [20];
        logic [7:0]  data;
        for (int i = 0; i < 20; i++)
        begin
            addrs[i] = 11'($urandom);
            data     = 8'($urandom);
            mirror[addrs[i]] = data;
            run_write(addrs[i], data, 1'b0);
        end
        for (int i = 0; i < 20; i++)
            run_read(addrs[i], mirror[addrs[i]], 1'b0);
    endtask

    initial
    begin
        void'($urandom(32'hbfc2_a122));
        RESET  = 1'b1;
        req    = '0;
        refuse = 1'b0;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        test_reset_state();
        test_write_read();
        test_blocks();
        test_refusal();
        test_busy_strobe();
        test_random();
        if (err_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- vlog.f
src/eeprom_pkg.sv
src/i2c_tx_shifter.sv
src/i2c_rx_shifter.sv
src/eeprom_sequencer.sv
src/eeprom_ctrl_top.sv
verification/eeprom_model.sv
verification/eeprom_ctrl_assertions.sv
verification/tb_eeprom_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the EEPROM controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_eeprom_ctrl \
    -f vlog.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
